//--- verilog/rx_macros.svh
// Receiver constants
// RS block geometry, GF(2^8) field polynomial and output FIFO sizing
// shared by the byte-domain receive path

`ifndef RX_MACROS_SVH
`define RX_MACROS_SVH

// symbols per RS block
`define RX_RS_N         16
// data symbols per block, the rest are check symbols
`define RX_RS_K         14
// symbol counter width, covers RX_RS_N with headroom
`define RX_SYM_CNT_W    5

// low byte of x^8 + x^4 + x^3 + x^2 + 1
`define RX_GF_POLY      8'h1d

// output word FIFO, depth must equal 2**RX_FIFO_AW
`define RX_FIFO_DEPTH   16
`define RX_FIFO_AW      4

// ATI byte-enable, valid bytes minus one
`define RX_BE_W         2

`endif

//--- verilog/rx_pkg.sv
// Receiver package
// types shared by the packer, the word FIFO and the top level

package rx_pkg;

    // one ATI output word, seen per byte lane or as a flat 32-bit word
    typedef union packed {
        logic [3:0][7:0] lane;
        logic [31:0]     data;
    } ati_word_u;

endpackage

//--- verilog/rx_symbol_tagger.sv
// RS symbol tagger
// first delay stage of the byte stream from the serial-to-parallel stage,
// numbers the symbols of each RS block and tags data and check symbols,
// also counts received blocks by their end-of-packet pulses

`timescale 1ns/1ps
`include "rx_macros.svh"

module rx_symbol_tagger (
    input  logic       parallel_clk_out,
    input  logic       i_serial_rx_rst_n,
    input  logic [7:0] i_parallel_data,
    input  logic       i_parallel_en,
    input  logic       i_parallel_sop,
    input  logic       i_parallel_eop,
    output logic [7:0] o_data,
    output logic       o_sof,
    output logic       o_data_sym,
    output logic       o_check_sym,
    output logic       o_last_sym,
    output logic       o_last_data,
    output logic [7:0] o_sync_cnt
);

    localparam logic [`RX_SYM_CNT_W-1:0] DATA_CNT  = `RX_SYM_CNT_W'(`RX_RS_K);
    localparam logic [`RX_SYM_CNT_W-1:0] BLOCK_CNT = `RX_SYM_CNT_W'(`RX_RS_N);
    localparam logic [`RX_SYM_CNT_W-1:0] LAST_DATA = `RX_SYM_CNT_W'(`RX_RS_K - 1);
    localparam logic [`RX_SYM_CNT_W-1:0] LAST_SYM  = `RX_SYM_CNT_W'(`RX_RS_N - 1);

    logic [`RX_SYM_CNT_W-1:0] r_sym_cnt;
    logic                     r_en_d1;
    logic                     r_sop_d1;
    logic [7:0]               r_sync_cnt;

//==========================================================================
// delay stage and symbol counter
//==========================================================================
    // counter tracks the index of the byte held in the delay stage
    always_ff @(posedge parallel_clk_out or negedge i_serial_rx_rst_n) begin
        if (!i_serial_rx_rst_n) begin
            r_sym_cnt <= '0;
            r_en_d1   <= 1'b0;
            r_sop_d1  <= 1'b0;
        end else begin
            r_en_d1  <= i_parallel_en;
            r_sop_d1 <= i_parallel_sop;
            // sop wins so the first symbol is index 0
            if (i_parallel_sop) begin
                r_sym_cnt <= '0;
            end else if (i_parallel_en) begin
                r_sym_cnt <= r_sym_cnt + 1'b1;
            end
        end
    end

    // delayed byte payload
    always_ff @(posedge parallel_clk_out) begin
        o_data <= i_parallel_data;
    end

//==========================================================================
// block counter
//==========================================================================
    // one count per eop wrapping at 8 bits
    always_ff @(posedge parallel_clk_out or negedge i_serial_rx_rst_n) begin
        if (!i_serial_rx_rst_n) begin
            r_sync_cnt <= 8'd0;
        end else if (i_parallel_eop) begin
            r_sync_cnt <= r_sync_cnt + 8'd1;
        end
    end

    assign o_sync_cnt = r_sync_cnt;

    // tags for the delayed byte
    assign o_sof       = r_sop_d1 & r_en_d1;
    assign o_data_sym  = r_en_d1 & (r_sym_cnt < DATA_CNT);
    assign o_check_sym = r_en_d1 & (r_sym_cnt >= DATA_CNT) & (r_sym_cnt < BLOCK_CNT);
    // last data symbol ends the payload seen by the packer
    assign o_last_data = r_en_d1 & (r_sym_cnt == LAST_DATA);
    assign o_last_sym  = r_en_d1 & (r_sym_cnt == LAST_SYM);

endmodule

//--- verilog/rx_rs_syndrome.sv
// RS syndrome checker
// evaluates S1 and S2 of each RS block over GF(2^8) by Horner's rule,
// flags a block with any nonzero syndrome and counts failing blocks

`timescale 1ns/1ps
`include "rx_macros.svh"

module rx_rs_syndrome (
    input  logic       parallel_clk_out,
    input  logic       i_serial_rx_rst_n,
    input  logic [7:0] i_data,
    input  logic       i_sof,
    input  logic       i_data_sym,
    input  logic       i_check_sym,
    input  logic       i_last_sym,
    output logic       o_rs_err_found,
    output logic [7:0] o_rs_err_num
);

    logic [7:0] r_s1;
    logic [7:0] r_s2;
    logic [7:0] c_s1_base;
    logic [7:0] c_s2_base;
    logic [7:0] c_s1;
    logic [7:0] c_s2;
    logic       c_sym_en;
    logic       c_bad;

    // multiply by alpha, shift and reduce by the field polynomial
    function automatic logic [7:0] gf_mul_alpha(input logic [7:0] x);
        gf_mul_alpha = {x[6:0], 1'b0} ^ (x[7] ? `RX_GF_POLY : 8'h00);
    endfunction

//==========================================================================
// Horner step
//==========================================================================
    // every symbol of the block takes part, data and check alike
    assign c_sym_en = i_data_sym | i_check_sym;

    // sof restarts from the symbol itself
    assign c_s1_base = i_sof ? 8'h00 : r_s1;
    assign c_s2_base = i_sof ? 8'h00 : r_s2;

    // S1 = S1*alpha + r, S2 = S2*alpha^2 + r
    assign c_s1 = gf_mul_alpha(c_s1_base) ^ i_data;
    assign c_s2 = gf_mul_alpha(gf_mul_alpha(c_s2_base)) ^ i_data;

    // final syndromes on the last symbol
    assign c_bad = (c_s1 != 8'h00) | (c_s2 != 8'h00);

    always_ff @(posedge parallel_clk_out or negedge i_serial_rx_rst_n) begin
        if (!i_serial_rx_rst_n) begin
            r_s1 <= 8'h00;
            r_s2 <= 8'h00;
        end else if (c_sym_en) begin
            r_s1 <= c_s1;
            r_s2 <= c_s2;
        end
    end

//==========================================================================
// block result
//==========================================================================
    // one-cycle flag after the last symbol, count saturates at 255
    always_ff @(posedge parallel_clk_out or negedge i_serial_rx_rst_n) begin
        if (!i_serial_rx_rst_n) begin
            o_rs_err_found <= 1'b0;
            o_rs_err_num   <= 8'd0;
        end else begin
            o_rs_err_found <= c_sym_en & i_last_sym & c_bad;
            if (c_sym_en && i_last_sym && c_bad && (o_rs_err_num != 8'hff)) begin
                o_rs_err_num <= o_rs_err_num + 8'd1;
            end
        end
    end

endmodule

//--- verilog/rx_word_packer.sv
// ATI word packer
// takes the data symbols of each block and packs them into 32-bit words
// from lane 0 upward, one byte per word in x1 mode, with sof, eof and
// a byte-enable that holds the valid byte count minus one

`timescale 1ns/1ps
`include "rx_macros.svh"

module rx_word_packer (
    input  logic                parallel_clk_out,
    input  logic                i_serial_rx_rst_n,
    input  logic                i_x1_mode,
    input  logic [7:0]          i_byte,
    input  logic                i_val,
    input  logic                i_first,
    input  logic                i_last,
    output rx_pkg::ati_word_u   o_word,
    output logic                o_sof,
    output logic                o_eof,
    output logic [`RX_BE_W-1:0] o_be,
    output logic                o_wr
);

    // next free lane and the partial word
    logic [`RX_BE_W-1:0] r_lane;
    logic                r_sof_pend;
    rx_pkg::ati_word_u   r_acc;

    logic [`RX_BE_W-1:0] c_lane;
    logic                c_sof;
    logic                c_done;
    rx_pkg::ati_word_u   c_word;

//==========================================================================
// lane fill
//==========================================================================
    always_comb begin
        // a new block always starts at lane 0
        c_lane = i_first ? '0 : r_lane;
        // word holds the first byte of its block
        c_sof  = (c_lane == '0) ? i_first : r_sof_pend;
        // full word, end of payload, or single byte in x1
        c_done = i_x1_mode | i_last | (c_lane == '1);
        // lanes above the current byte stay zero
        c_word = (c_lane == '0) ? '0 : r_acc;
        c_word.lane[c_lane] = i_byte;
    end

//==========================================================================
// word output
//==========================================================================
    always_ff @(posedge parallel_clk_out or negedge i_serial_rx_rst_n) begin
        if (!i_serial_rx_rst_n) begin
            r_lane     <= '0;
            r_sof_pend <= 1'b0;
            o_wr       <= 1'b0;
            o_sof      <= 1'b0;
            o_eof      <= 1'b0;
            o_be       <= '0;
        end else begin
            o_wr <= i_val & c_done;
            if (i_val) begin
                if (c_done) begin
                    // flags for the word leaving this cycle
                    r_lane     <= '0;
                    r_sof_pend <= 1'b0;
                    o_sof      <= c_sof;
                    o_eof      <= i_last;
                    o_be       <= c_lane;
                end else begin
                    r_lane     <= c_lane + 1'b1;
                    r_sof_pend <= c_sof;
                end
            end
        end
    end

    // finished word out or partial word kept
    always_ff @(posedge parallel_clk_out) begin
        if (i_val) begin
            if (c_done) begin
                o_word <= c_word;
            end else begin
                r_acc <= c_word;
            end
        end
    end

endmodule

//--- verilog/rx_word_fifo.sv
// ATI word FIFO
// synchronous first-word-fall-through FIFO between the packer and the
// ATI port, absorbs i_rdy back-pressure, drops writes when full and
// keeps a sticky overflow flag

`timescale 1ns/1ps
`include "rx_macros.svh"

module rx_word_fifo (
    input  logic                parallel_clk_out,
    input  logic                i_serial_rx_rst_n,
    input  logic                i_wr,
    input  rx_pkg::ati_word_u   i_word,
    input  logic                i_sof,
    input  logic                i_eof,
    input  logic [`RX_BE_W-1:0] i_be,
    output logic                o_val,
    output logic                o_sof,
    output logic                o_eof,
    output logic [`RX_BE_W-1:0] o_be,
    output logic [31:0]         o_data,
    output logic                o_overflow,
    input  logic                i_rdy
);

    // word and flags per entry
    rx_pkg::ati_word_u   mem_word [0:`RX_FIFO_DEPTH-1];
    logic                mem_sof  [0:`RX_FIFO_DEPTH-1];
    logic                mem_eof  [0:`RX_FIFO_DEPTH-1];
    logic [`RX_BE_W-1:0] mem_be   [0:`RX_FIFO_DEPTH-1];

    // one extra wrap bit tells full from empty
    logic [`RX_FIFO_AW:0] r_wptr;
    logic [`RX_FIFO_AW:0] r_rptr;

    logic c_empty;
    logic c_full;
    logic c_push;
    logic c_pop;

    assign c_empty = (r_wptr == r_rptr);
    assign c_full  = (r_wptr[`RX_FIFO_AW] != r_rptr[`RX_FIFO_AW]) &&
                     (r_wptr[`RX_FIFO_AW-1:0] == r_rptr[`RX_FIFO_AW-1:0]);
    assign c_push  = i_wr & ~c_full;
    assign c_pop   = o_val & i_rdy;

//==========================================================================
// pointers and overflow
//==========================================================================
    always_ff @(posedge parallel_clk_out or negedge i_serial_rx_rst_n) begin
        if (!i_serial_rx_rst_n) begin
            r_wptr     <= '0;
            r_rptr     <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (c_push) begin
                r_wptr <= r_wptr + 1'b1;
            end
            if (c_pop) begin
                r_rptr <= r_rptr + 1'b1;
            end
            // write into a full FIFO is lost
            if (i_wr && c_full) begin
                o_overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge parallel_clk_out) begin
        if (c_push) begin
            mem_word[r_wptr[`RX_FIFO_AW-1:0]] <= i_word;
            mem_sof[r_wptr[`RX_FIFO_AW-1:0]]  <= i_sof;
            mem_eof[r_wptr[`RX_FIFO_AW-1:0]]  <= i_eof;
            mem_be[r_wptr[`RX_FIFO_AW-1:0]]   <= i_be;
        end
    end

    // head entry shows through, held until popped
    assign o_val  = ~c_empty;
    assign o_data = mem_word[r_rptr[`RX_FIFO_AW-1:0]].data;
    assign o_sof  = mem_sof[r_rptr[`RX_FIFO_AW-1:0]];
    assign o_eof  = mem_eof[r_rptr[`RX_FIFO_AW-1:0]];
    assign o_be   = mem_be[r_rptr[`RX_FIFO_AW-1:0]];

endmodule

//--- verilog/rx_top.sv
// Receiver byte-domain top
// symbol tagging, RS syndrome check, check-symbol removal and packing
// of the received byte stream into ATI words through a word FIFO

`timescale 1ns/1ps
`include "rx_macros.svh"

module rx_top (
    input  logic                parallel_clk_out,
    input  logic                i_serial_rx_rst_n,
    input  logic [7:0]          i_parallel_data,
    input  logic                i_parallel_en,
    input  logic                i_parallel_sop,
    input  logic                i_parallel_eop,
    input  logic                i_x1_mode,
    input  logic                i_ati_rdy,
    output logic                o_ati_val,
    output logic                o_ati_sof,
    output logic                o_ati_eof,
    output logic [`RX_BE_W-1:0] o_ati_be,
    output logic [31:0]         o_ati_data,
    output logic                o_rs_err_found,
    output logic [7:0]          o_rs_err_num,
    output logic [7:0]          o_sync_cnt,
    output logic                o_fifo_overflow
);

    // tagged symbol stream
    logic [7:0]          t_data;
    logic                t_sof;
    logic                t_data_sym;
    logic                t_check_sym;
    logic                t_last_sym;
    logic                t_last_data;

    // packed words into the FIFO
    rx_pkg::ati_word_u   w_word;
    logic                w_sof;
    logic                w_eof;
    logic [`RX_BE_W-1:0] w_be;
    logic                w_wr;

//==========================================================================
// tagging and syndrome check
//==========================================================================
    rx_symbol_tagger u_tagger (
        .parallel_clk_out (parallel_clk_out),
        .i_serial_rx_rst_n(i_serial_rx_rst_n),
        .i_parallel_data  (i_parallel_data),
        .i_parallel_en    (i_parallel_en),
        .i_parallel_sop   (i_parallel_sop),
        .i_parallel_eop   (i_parallel_eop),
        .o_data           (t_data),
        .o_sof            (t_sof),
        .o_data_sym       (t_data_sym),
        .o_check_sym      (t_check_sym),
        .o_last_sym       (t_last_sym),
        .o_last_data      (t_last_data),
        .o_sync_cnt       (o_sync_cnt)
    );

    rx_rs_syndrome u_syndrome (
        .parallel_clk_out (parallel_clk_out),
        .i_serial_rx_rst_n(i_serial_rx_rst_n),
        .i_data           (t_data),
        .i_sof            (t_sof),
        .i_data_sym       (t_data_sym),
        .i_check_sym      (t_check_sym),
        .i_last_sym       (t_last_sym),
        .o_rs_err_found   (o_rs_err_found),
        .o_rs_err_num     (o_rs_err_num)
    );

//==========================================================================
// packing and output FIFO
//==========================================================================
    // only data symbols reach the packer
    rx_word_packer u_packer (
        .parallel_clk_out (parallel_clk_out),
        .i_serial_rx_rst_n(i_serial_rx_rst_n),
        .i_x1_mode        (i_x1_mode),
        .i_byte           (t_data),
        .i_val            (t_data_sym),
        .i_first          (t_sof),
        .i_last           (t_last_data),
        .o_word           (w_word),
        .o_sof            (w_sof),
        .o_eof            (w_eof),
        .o_be             (w_be),
        .o_wr             (w_wr)
    );

    rx_word_fifo u_fifo (
        .parallel_clk_out (parallel_clk_out),
        .i_serial_rx_rst_n(i_serial_rx_rst_n),
        .i_wr             (w_wr),
        .i_word           (w_word),
        .i_sof            (w_sof),
        .i_eof            (w_eof),
        .i_be             (w_be),
        .o_val            (o_ati_val),
        .o_sof            (o_ati_sof),
        .o_eof            (o_ati_eof),
        .o_be             (o_ati_be),
        .o_data           (o_ati_data),
        .o_overflow       (o_fifo_overflow),
        .i_rdy            (i_ati_rdy)
    );

endmodule

//--- tests/rx_top_assert.sv
// ATI protocol assertions
// bound to the receiver top, checks quiet outputs around reset
// and a steady word under back-pressure

`timescale 1ns/1ps
`include "rx_macros.svh"

module rx_top_assert (
    input logic                parallel_clk_out,
    input logic                i_serial_rx_rst_n,
    input logic                i_ati_rdy,
    input logic                o_ati_val,
    input logic                o_ati_sof,
    input logic                o_ati_eof,
    input logic [`RX_BE_W-1:0] o_ati_be,
    input logic [31:0]         o_ati_data,
    input logic                o_rs_err_found
);

    // failures seen so far
    int fail_cnt = 0;

    // nothing valid while reset is applied
    a_reset_quiet: assert property (@(posedge parallel_clk_out)
        !i_serial_rx_rst_n |-> (!o_ati_val && !o_rs_err_found))
        else begin fail_cnt++; $error("ATI valid or RS error flag high in reset"); end

    // still quiet in the first cycle after release
    a_release_quiet: assert property (@(posedge parallel_clk_out)
        $rose(i_serial_rx_rst_n) |=> (!o_ati_val && !o_rs_err_found))
        else begin fail_cnt++; $error("ATI valid or RS error flag high after reset"); end

    // stalled word and its flags hold until taken
    a_hold: assert property (@(posedge parallel_clk_out) disable iff (!i_serial_rx_rst_n)
        (o_ati_val && !i_ati_rdy) |=> (o_ati_val && $stable(o_ati_data) &&
            $stable(o_ati_sof) && $stable(o_ati_eof) && $stable(o_ati_be)))
        else begin fail_cnt++; $error("ATI word changed while stalled"); end

endmodule

//--- tests/rx_top_tb.sv
// Receiver byte-domain testbench
// sends RS blocks of random, solved-clean and all-zero symbols in x4 and
// x1 mode, under random ATI back-pressure in part of the run, and checks
// output words, RS error pulses and the block and error counters

`timescale 1ns/1ps
`include "rx_macros.svh"

module rx_top_tb;

    localparam int N          = `RX_RS_N;
    localparam int K          = `RX_RS_K;
    localparam int PERIOD     = 4;
    localparam int RST_CYCLES = 4;
    localparam int MAX_GAP    = 5;
    localparam int NUM_BLOCKS = 14;
    localparam int TIMEOUT_NS = 2 * (RST_CYCLES + NUM_BLOCKS * (N + MAX_GAP)) * PERIOD;
    localparam int KIND_RAND   = 0;
    localparam int KIND_SOLVED = 1;
    localparam int KIND_ZERO   = 2;
    localparam int KIND_MIX    = 3;

    logic                parallel_clk_out;
    logic                i_serial_rx_rst_n;
    logic [7:0]          i_parallel_data;
    logic                i_parallel_en;
    logic                i_parallel_sop;
    logic                i_parallel_eop;
    logic                i_x1_mode;
    logic                i_ati_rdy;
    logic                o_ati_val;
    logic                o_ati_sof;
    logic                o_ati_eof;
    logic [`RX_BE_W-1:0] o_ati_be;
    logic [31:0]         o_ati_data;
    logic                o_rs_err_found;
    logic [7:0]          o_rs_err_num;
    logic [7:0]          o_sync_cnt;
    logic                o_fifo_overflow;

    integer      seed;
    string       test_name;
    logic        rdy_rand;
    logic [7:0]  blk [0:N-1];
    logic        blk_bad;
    int          exp_err_cnt;
    int          eop_cnt;
    int          cyc;
    // {sof, eof, be, data} per expected word
    logic [35:0] exp_q [$];
    // cycle and expected flag of each pending RS result
    int          due_q [$];
    logic        flag_q [$];

    rx_top DUT (.*);

    bind rx_top rx_top_assert u_assert (
        .parallel_clk_out (parallel_clk_out),
        .i_serial_rx_rst_n(i_serial_rx_rst_n),
        .i_ati_rdy        (i_ati_rdy),
        .o_ati_val        (o_ati_val),
        .o_ati_sof        (o_ati_sof),
        .o_ati_eof        (o_ati_eof),
        .o_ati_be         (o_ati_be),
        .o_ati_data       (o_ati_data),
        .o_rs_err_found   (o_rs_err_found)
    );

    always #(PERIOD / 2) parallel_clk_out = ~parallel_clk_out;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

//============================================================================
// reference model
//============================================================================
    // plain shift-and-add multiply in GF(2^8)
    function automatic logic [7:0] gf_mult(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        int         i;
        p = 8'h00;
        x = a;
        for (i = 0; i < 8; i++) begin
            if (b[i]) p = p ^ x;
            x = {x[6:0], 1'b0} ^ (x[7] ? `RX_GF_POLY : 8'h00);
        end
        return p;
    endfunction

    // Horner evaluation of the first len symbols at root
    function automatic logic [7:0] poly_eval(input logic [7:0] root, input int len);
        logic [7:0] acc;
        int         i;
        acc = 8'h00;
        for (i = 0; i < len; i++) acc = gf_mult(acc, root) ^ blk[i];
        return acc;
    endfunction

    // pick the two last symbols so that S1 and S2 both come out zero
    task automatic solve_check_symbols();
        logic [7:0] a_term;
        logic [7:0] b_term;
        logic [7:0] r_lo;
        int         c;
        a_term = gf_mult(poly_eval(8'h02, N - 2), 8'h04);
        b_term = gf_mult(poly_eval(8'h04, N - 2), 8'h10);
        for (c = 0; c < 256; c++) begin
            r_lo = c[7:0];
            if ((gf_mult(r_lo, 8'h04) ^ a_term ^ gf_mult(r_lo, 8'h02)) == b_term) begin
                blk[N-2] = r_lo;
                blk[N-1] = a_term ^ gf_mult(r_lo, 8'h02);
            end
        end
    endtask

    // words of one block, lanes filled from lane 0, one byte each in x1
    task automatic expect_words();
        int          grp;
        int          base;
        int          cnt;
        int          b;
        logic [31:0] data;
        grp = i_x1_mode ? 1 : 4;
        for (base = 0; base < K; base += grp) begin
            cnt  = (K - base < grp) ? K - base : grp;
            data = 32'h0;
            for (b = 0; b < cnt; b++) data[8*b +: 8] = blk[base + b];
            exp_q.push_back({base == 0, base + cnt == K, 2'(cnt - 1), data});
        end
    endtask

//============================================================================
// stimulus
//============================================================================
    // inputs change just after the rising edge
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge parallel_clk_out);
        #0.5;
        r = $random(seed);
        i_ati_rdy = rdy_rand ? r[0] : 1'b1;
    endtask

    task automatic send_block(input int kind);
        logic [31:0] r;
        int          i;
        int          idle;
        for (i = 0; i < N; i++) begin
            r = $random(seed);
            blk[i] = (kind == KIND_ZERO) ? 8'h00 : r[7:0];
        end
        if (kind == KIND_SOLVED) solve_check_symbols();
        blk_bad = (poly_eval(8'h02, N) != 8'h00) || (poly_eval(8'h04, N) != 8'h00);
        if (blk_bad) exp_err_cnt++;
        eop_cnt++;
        expect_words();
        for (i = 0; i < N; i++) begin
            next_cycle();
            i_parallel_data = blk[i];
            i_parallel_en   = 1'b1;
            i_parallel_sop  = (i == 0);
            i_parallel_eop  = (i == N - 1);
        end
        // at least two idle cycles, so the mode may change afterwards
        r    = $random(seed);
        idle = 2 + int'(r[7:0]) % (MAX_GAP - 1);
        next_cycle();
        i_parallel_data = 8'h00;
        i_parallel_en   = 1'b0;
        i_parallel_sop  = 1'b0;
        i_parallel_eop  = 1'b0;
        repeat (idle - 1) next_cycle();
    endtask

    task automatic run_phase(input string name, input logic x1, input logic bp,
                             input int kind, input int count);
        int i;
        test_name = name;
        i_x1_mode = x1;
        rdy_rand  = bp;
        for (i = 0; i < count; i++) begin
            send_block((kind == KIND_MIX) ? i % 3 : kind);
        end
    endtask

    initial begin
        seed              = 32'h2e9a;
        test_name         = "reset";
        parallel_clk_out  = 1'b0;
        i_serial_rx_rst_n = 1'b0;
        i_parallel_data   = 8'h00;
        i_parallel_en     = 1'b0;
        i_parallel_sop    = 1'b0;
        i_parallel_eop    = 1'b0;
        i_x1_mode         = 1'b0;
        i_ati_rdy         = 1'b0;
        rdy_rand          = 1'b0;
        blk_bad           = 1'b0;
        exp_err_cnt       = 0;
        eop_cnt           = 0;
        cyc               = 0;
        repeat (RST_CYCLES) @(posedge parallel_clk_out);
        #0.5;
        i_serial_rx_rst_n = 1'b1;

        run_phase("x4_random", 1'b0, 1'b1, KIND_RAND, 6);
        run_phase("x4_clean", 1'b0, 1'b1, KIND_SOLVED, 4);
        run_phase("x4_zero", 1'b0, 1'b0, KIND_ZERO, 1);
        run_phase("x1_mixed", 1'b1, 1'b0, KIND_MIX, 3);

        // let the FIFO and the last RS result drain
        test_name = "drain";
        rdy_rand  = 1'b0;
        while (exp_q.size() != 0 || due_q.size() != 0) next_cycle();

        test_name = "counters";
        assert (o_rs_err_num == 8'(exp_err_cnt)) else stop_with_failure($sformatf(
            "Mismatch in %s: expected %0d, actual %0d", test_name, exp_err_cnt, o_rs_err_num));
        assert (o_sync_cnt == 8'(eop_cnt)) else stop_with_failure($sformatf(
            "Mismatch in %s: expected %0d, actual %0d", test_name, eop_cnt, o_sync_cnt));
        if (DUT.u_assert.fail_cnt == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_with_failure("a bound ATI protocol assertion failed during the run");
        end
    end

//============================================================================
// monitor and scoreboard
//============================================================================
    // outputs sampled mid-cycle, a word moves on the next rising edge
    always @(negedge parallel_clk_out) begin
        logic        exp_found;
        logic [35:0] exp_word;
        logic [35:0] act_word;
        if (i_serial_rx_rst_n) begin
            cyc++;
            exp_found = 1'b0;
            if (due_q.size() != 0 && due_q[0] == cyc) begin
                exp_found = flag_q.pop_front();
                void'(due_q.pop_front());
            end
            assert (o_rs_err_found == exp_found) else stop_with_failure($sformatf(
                "Mismatch in %s: expected %0b, actual %0b", test_name, exp_found,
                o_rs_err_found));
            // RS result two cycles after the eop byte
            if (i_parallel_eop) begin
                due_q.push_back(cyc + 2);
                flag_q.push_back(blk_bad);
            end
            if (o_ati_val && i_ati_rdy) begin
                assert (exp_q.size() != 0) else stop_with_failure($sformatf(
                    "Error in %s: an ATI word came out with none expected", test_name));
                exp_word = exp_q.pop_front();
                act_word = {o_ati_sof, o_ati_eof, o_ati_be, o_ati_data};
                assert (act_word == exp_word) else stop_with_failure($sformatf(
                    "Mismatch in %s: expected %h, actual %h", test_name, exp_word, act_word));
            end
            assert (!o_fifo_overflow) else stop_with_failure($sformatf(
                "Error in %s: the output FIFO overflowed and dropped a word", test_name));
            assert (DUT.u_assert.fail_cnt == 0) else stop_with_failure($sformatf(
                "Error in %s: a bound ATI protocol assertion failed", test_name));
        end
    end

    // watchdog, sized from block count, block length and largest gap
    initial begin
        #(TIMEOUT_NS);
        stop_with_failure("Timeout: the run did not finish in the expected time");
    end

endmodule

//--- all.f
+incdir+verilog
verilog/rx_pkg.sv
verilog/rx_symbol_tagger.sv
verilog/rx_rs_syndrome.sv
verilog/rx_word_packer.sv
verilog/rx_word_fifo.sv
verilog/rx_top.sv
tests/rx_top_assert.sv
tests/rx_top_tb.sv

//--- Makefile
# Verilator build and run of the receiver testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       ?= rx_top_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "Test OK" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
